//--- source/arcade_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arcade shell types: game variant, player controls,
// host status word and the PIA input port bundle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package arcade_pkg;

	// Game variant selected by the host
	typedef enum logic [1:0] {
		defender = 2'd0,
		colony7  = 2'd1,
		mayday   = 2'd2,
		jin      = 2'd3
	} game_e;

	// Decoded player one controls
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
		logic fire_c;
		logic fire_d;
		logic coin1;
		logic coin2;
		logic start1;
		logic start2;
	} player_t;

	// Host status bits
	typedef struct packed {
		logic       reset_req;    // Host reset request
		logic       auto_up;
		logic       advance_btn;
		logic       hs_reset_btn; // High score reset
		logic [2:0] dip;
		logic       spare;
	} status_t;

	// What the game core sees on its PIAs
	typedef struct packed {
		logic [7:0] input0;
		logic [7:0] input1;
		logic [7:0] input2;
		logic       mayday;      // Protection enable
		logic [1:0] orientation; // [left/right, landscape/portrait]
	} pia_ports_t;

	localparam int PULSE_LEN = 4096; // Service pulse, in clk_sys cycles
	localparam int PULSE_W   = $clog2(PULSE_LEN + 1);

endpackage

//--- source/loader_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ROM download stream and ROM region layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package loader_pkg;

	// Byte stream from the host download link
	typedef struct packed {
		logic        download; // High for a whole download
		logic [7:0]  index;
		logic        wr;       // One cycle per byte
		logic [15:0] addr;
		logic [7:0]  data;
	} dl_t;

	// Write port into the ROM store
	typedef struct packed {
		logic        main_we;
		logic        snd_we;
		logic [14:0] addr;
		logic [7:0]  data;
	} rom_wr_t;

	// Download image layout
	//   0000-6FFF main cpu program
	//   7000-73FF decoder
	//   7400-7BFF sound cpu
	localparam int          MAIN_SIZE = 29696;
	localparam logic [15:0] SND_BASE  = 16'h7400;
	localparam int          SND_SIZE  = 2048;
	localparam logic [7:0]  ROM_INDEX = 8'h00;

	localparam int MAIN_AW = $clog2(MAIN_SIZE);
	localparam int SND_AW  = $clog2(SND_SIZE);

endpackage

//--- source/button_stretch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Service button stretcher
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module button_stretch (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic btn,
	output logic pulse
);
	import arcade_pkg::*;

	logic               btn_q;
	logic               btn_qq;
	logic [PULSE_W-1:0] count;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			btn_q  <= 1'b0;
			btn_qq <= 1'b0;
			count  <= '0;
		end else begin
			btn_q  <= btn;
			btn_qq <= btn_q;
			if (btn_q && !btn_qq)
				count <= PULSE_W'(PULSE_LEN); // Press restarts the count
			else if (count != '0)
				count <= count - 1'b1;
		end
	end

	assign pulse = (count != '0);

endmodule

//--- source/control_mapper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-variant mapping of controls and DIPs
// onto the three PIA input bytes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module control_mapper (
	input  arcade_pkg::game_e      variant,
	input  arcade_pkg::player_t    controls,
	input  arcade_pkg::status_t    status,
	input  logic                   advance,
	input  logic                   hs_reset,
	output arcade_pkg::pia_ports_t ports
);
	import arcade_pkg::*;

	always_comb begin
		ports             = '0;
		ports.orientation = 2'd2; // Landscape unless the game says otherwise

		case (variant)
			defender: begin
				// Coin, score reset, advance, auto up
				ports.input0 = {3'b000, controls.coin1, hs_reset, 1'b0, advance,
					status.auto_up};
				ports.input1 = {controls.down, controls.left | controls.right,
					controls.start1, controls.start2, controls.fire_d,
					controls.fire_c, controls.fire_b, controls.fire_a};
				ports.input2 = {7'b0000000, controls.up};
			end

			colony7: begin
				ports.orientation = 2'd1;
				ports.input0 = {3'b000, controls.coin1, 2'b00, status.dip[1:0]}; // Bonus, lives
				ports.input1 = {controls.fire_b, controls.fire_a, controls.start1,
					controls.start2, controls.up, controls.left, controls.right,
					controls.down};
				ports.input2 = {7'b0000000, controls.fire_c};
			end

			mayday: begin
				ports.mayday = 1'b1;
				ports.input0 = {2'b00, controls.coin2, controls.coin1, 1'b0, hs_reset,
					advance, status.auto_up};
				ports.input1 = {controls.down, 1'b0, controls.start1, controls.start2,
					controls.fire_b, controls.fire_c, controls.right, controls.fire_a};
				ports.input2 = {7'b0000000, controls.up};
			end

			jin: begin
				ports.orientation = 2'd3;
				ports.input0 = {3'b000, controls.coin2, controls.coin1, 3'b000};
				ports.input1 = {controls.fire_b, controls.fire_a, controls.start1,
					controls.start2, controls.right, controls.left, controls.down,
					controls.up};
				// Level DIPs are active low, lives DIP is not
				ports.input2 = {1'b0, ~status.dip[2:1], 1'b0, status.dip[0], 3'b000};
			end

			default: ;
		endcase
	end

endmodule

//--- source/rom_loader.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ROM download router and core reset control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rom_loader (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  loader_pkg::dl_t     dl,
	input  logic                reset_req,
	output loader_pkg::rom_wr_t rom_wr,
	output logic                rom_loaded,
	output logic                core_reset
);
	import loader_pkg::*;

	logic        rom_hit;
	logic        main_hit;
	logic        snd_hit;
	logic [15:0] snd_off;

	logic        main_we_q;
	logic        snd_we_q;
	logic [14:0] addr_q;
	logic [7:0]  data_q;
	logic        download_q;

	assign rom_hit  = dl.download && dl.wr && (dl.index == ROM_INDEX);
	assign snd_off  = dl.addr - SND_BASE;
	assign main_hit = rom_hit && (dl.addr < SND_BASE);
	assign snd_hit  = rom_hit && (dl.addr >= SND_BASE) && (snd_off < 16'(SND_SIZE));

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			main_we_q <= 1'b0;
			snd_we_q  <= 1'b0;
		end else begin
			main_we_q <= main_hit;
			snd_we_q  <= snd_hit;
		end
	end

	// Sound bytes land at their offset within the sound region
	always_ff @(posedge clk_sys) begin
		addr_q <= main_hit ? dl.addr[14:0] : snd_off[14:0];
		data_q <= dl.data;
	end

	always_comb begin
		rom_wr.main_we = main_we_q;
		rom_wr.snd_we  = snd_we_q;
		rom_wr.addr    = addr_q;
		rom_wr.data    = data_q;
	end

	// Game stays in reset until a full download has gone by
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			download_q <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			download_q <= dl.download;
			if (download_q && !dl.download)
				rom_loaded <= 1'b1; // End of download
			core_reset <= reset_req | dl.download | ~rom_loaded;
		end
	end

endmodule

//--- source/rom_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Main and sound ROM byte stores
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rom_store (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  loader_pkg::rom_wr_t rom_wr,
	input  logic [14:0]         main_addr,
	output logic [7:0]          main_data,
	input  logic [10:0]         snd_addr,
	input  logic                snd_vma,
	output logic [7:0]          snd_data
);
	import loader_pkg::*;

	logic [7:0] main_mem [MAIN_SIZE];
	logic [7:0] snd_mem  [SND_SIZE];

	logic              vma_q1;
	logic              vma_q2;
	logic [SND_AW-1:0] snd_addr_q; // Address seen by the sound CPU

	always_ff @(posedge clk_sys) begin
		if (rom_wr.main_we)
			main_mem[rom_wr.addr] <= rom_wr.data;
		if (rom_wr.snd_we)
			snd_mem[rom_wr.addr[SND_AW-1:0]] <= rom_wr.data;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			main_data <= '0;
		end else begin
			main_data <= main_mem[main_addr];
		end
	end

	// Sound board samples the address late in the bus cycle
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			vma_q1     <= 1'b0;
			vma_q2     <= 1'b0;
			snd_addr_q <= '0;
			snd_data   <= '0;
		end else begin
			vma_q1 <= snd_vma;
			vma_q2 <= vma_q1;
			if (vma_q2)
				snd_addr_q <= snd_addr;
			snd_data <= snd_mem[snd_addr_q];
		end
	end

endmodule

//--- source/audio_dac.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// First-order sigma-delta audio DAC
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module audio_dac (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic [15:0] level,
	output logic        dac_out
);

	logic [15:0] acc;
	logic [16:0] sum;

	assign sum = {1'b0, acc} + {1'b0, level};

	// Carry rate tracks level / 65536
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= sum[15:0];
			dac_out <= sum[16];
		end
	end

endmodule

//--- source/arcade_shell.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arcade shell top: inputs, ROM loading
// and audio output around the game core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module arcade_shell (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  arcade_pkg::game_e      variant,
	input  arcade_pkg::player_t    controls,
	input  arcade_pkg::status_t    status,
	input  loader_pkg::dl_t        dl,
	input  logic [14:0]            main_addr,
	output logic [7:0]             main_data,
	input  logic [10:0]            snd_addr,
	input  logic                   snd_vma,
	output logic [7:0]             snd_data,
	input  logic [7:0]             audio,
	output arcade_pkg::pia_ports_t ports,
	output logic                   core_reset,
	output logic                   rom_loaded,
	output logic                   audio_out
);
	import loader_pkg::*;

	logic        advance;
	logic        hs_reset;
	rom_wr_t     rom_wr;
	logic [15:0] audio_level;

	// 16-bit sample at one eighth volume
	assign audio_level = {3'b000, audio, 5'b00000};

	button_stretch u_adv_stretch (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.btn     (status.advance_btn),
		.pulse   (advance)
	);

	button_stretch u_hsr_stretch (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.btn     (status.hs_reset_btn),
		.pulse   (hs_reset)
	);

	control_mapper u_control_mapper (
		.variant  (variant),
		.controls (controls),
		.status   (status),
		.advance  (advance),
		.hs_reset (hs_reset),
		.ports    (ports)
	);

	rom_loader u_rom_loader (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dl         (dl),
		.reset_req  (status.reset_req),
		.rom_wr     (rom_wr),
		.rom_loaded (rom_loaded),
		.core_reset (core_reset)
	);

	rom_store u_rom_store (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.rom_wr    (rom_wr),
		.main_addr (main_addr),
		.main_data (main_data),
		.snd_addr  (snd_addr),
		.snd_vma   (snd_vma),
		.snd_data  (snd_data)
	);

	audio_dac u_audio_dac (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.level   (audio_level),
		.dac_out (audio_out)
	);

endmodule

//--- test/tb_arcade_shell.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arcade shell testbench: ROM load, readback,
// port mapping, service pulses and audio density
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_arcade_shell;
	import arcade_pkg::*;
	import loader_pkg::*;

	// Test lengths add up to roughly 59000 cycles
	localparam int TIMEOUT_CYCLES = 60000;

	logic        clk_sys = 1'b0;
	logic        arst_n;
	game_e       variant;
	player_t     controls;
	status_t     status;
	dl_t         dl;
	logic [14:0] main_addr;
	logic [7:0]  main_data;
	logic [10:0] snd_addr;
	logic        snd_vma;
	logic [7:0]  snd_data;
	logic [7:0]  audio;
	pia_ports_t  ports;
	logic        core_reset;
	logic        rom_loaded;
	logic        audio_out;

	logic [7:0] main_model [MAIN_SIZE]; // Expected ROM contents
	logic [7:0] snd_model  [SND_SIZE];

	int    seed = 32'h96cd;
	int    cycles = 0;
	int    pass_count = 0;
	int    fail_count = 0;
	int    test_errs = 0;
	string cur_test = "";

	arcade_shell u_arcade_shell (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.variant    (variant),
		.controls   (controls),
		.status     (status),
		.dl         (dl),
		.main_addr  (main_addr),
		.main_data  (main_data),
		.snd_addr   (snd_addr),
		.snd_vma    (snd_vma),
		.snd_data   (snd_data),
		.audio      (audio),
		.ports      (ports),
		.core_reset (core_reset),
		.rom_loaded (rom_loaded),
		.audio_out  (audio_out)
	);

	always #20 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic step();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual, input logic [31:0] tol);
		logic [31:0] diff;
		diff = (expected > actual) ? expected - actual : actual - expected;
		if (diff > tol) begin
			fail_count++;
			test_errs++;
			$display("[ERROR] %s / %s: expected 0x%0h, actual 0x%0h", cur_test, name,
				expected, actual);
		end else begin
			pass_count++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		$display("Test %-16s done, %0d errors", cur_test, test_errs);
	endtask

	// Port table per game variant
	function automatic pia_ports_t expected_ports(input game_e v, input player_t c,
		input status_t s, input logic adv, input logic hsr);
		pia_ports_t p;
		p = '0;
		p.orientation = 2'd2;
		case (v)
			defender: begin
				p.input0[4] = c.coin1;
				p.input0[3] = hsr;
				p.input0[1] = adv;
				p.input0[0] = s.auto_up;
				p.input1 = {c.down, c.left | c.right, c.start1, c.start2,
					c.fire_d, c.fire_c, c.fire_b, c.fire_a};
				p.input2[0] = c.up;
			end
			colony7: begin
				p.orientation  = 2'd1;
				p.input0[4]    = c.coin1;
				p.input0[1:0]  = s.dip[1:0];
				p.input1 = {c.fire_b, c.fire_a, c.start1, c.start2,
					c.up, c.left, c.right, c.down};
				p.input2[0] = c.fire_c;
			end
			mayday: begin
				p.mayday    = 1'b1;
				p.input0[5] = c.coin2;
				p.input0[4] = c.coin1;
				p.input0[2] = hsr;
				p.input0[1] = adv;
				p.input0[0] = s.auto_up;
				p.input1 = {c.down, 1'b0, c.start1, c.start2,
					c.fire_b, c.fire_c, c.right, c.fire_a};
				p.input2[0] = c.up;
			end
			default: begin
				p.orientation = 2'd3;
				p.input0[4]   = c.coin2;
				p.input0[3]   = c.coin1;
				p.input1 = {c.fire_b, c.fire_a, c.start1, c.start2,
					c.right, c.left, c.down, c.up};
				p.input2[6:5] = ~s.dip[2:1];
				p.input2[3]   = s.dip[0];
			end
		endcase
		return p;
	endfunction

	task automatic start_download(input logic [7:0] idx);
		dl.download = 1'b1;
		dl.index    = idx;
		dl.wr       = 1'b0;
		step();
	endtask

	task automatic send_byte(input logic [15:0] addr, input logic [7:0] data);
		dl.wr   = 1'b1;
		dl.addr = addr;
		dl.data = data;
		step();
	endtask

	task automatic stop_download();
		dl.wr = 1'b0;
		step();
		step(); // Last write reaches the store
		dl.download = 1'b0;
	endtask

	task automatic read_main(input logic [14:0] ma);
		main_addr = ma;
		step();
		check($sformatf("main_data at %04h", ma), 32'(main_model[ma]), 32'(main_data), 32'd0);
	endtask

	// Strobe, then wait out the two-stage vma delay and the latch
	task automatic read_snd(input logic [10:0] sa);
		snd_addr = sa;
		snd_vma  = 1'b1;
		step();
		snd_vma = 1'b0;
		step();
		step();
		snd_addr = ~sa; // Bus moves on once the address is latched
		step();
		check($sformatf("snd_data at %03h", sa), 32'(snd_model[sa]), 32'(snd_data), 32'd0);
		step();
		check($sformatf("snd_data held at %03h", sa), 32'(snd_model[sa]), 32'(snd_data),
			32'd0);
	endtask

	task automatic pulse_test(input string name, input logic use_hsr, input logic [2:0] bit_idx);
		int n;
		int high_len;
		int first_high;
		start_test(name);
		variant  = defender;
		controls = '0;
		status   = '0;
		if (use_hsr)
			status.hs_reset_btn = 1'b1;
		else
			status.advance_btn = 1'b1;
		n          = 0;
		high_len   = 0;
		first_high = 0;
		while (n < PULSE_LEN + 16) begin
			step();
			n++;
			if (n == 3) begin
				status.advance_btn  = 1'b0; // Button held for 3 cycles
				status.hs_reset_btn = 1'b0;
			end
			#1;
			if (ports.input0[bit_idx]) begin
				if (high_len == 0)
					first_high = n;
				high_len++;
			end else if (high_len != 0) begin
				break;
			end
		end
		check("pulse start edge", 32'd2, 32'(first_high), 32'd0);
		check("pulse length", 32'(PULSE_LEN), 32'(high_len), 32'd0);
		end_test();
	endtask

	initial begin
		logic [31:0] r;
		logic [15:0] addr16;
		logic        reset_held;
		logic [14:0] ff_main [$];
		logic [10:0] ff_snd [$];
		logic [7:0]  value;
		int          ones;

		arst_n    = 1'b0;
		variant   = defender;
		controls  = '0;
		status    = '0;
		dl        = '0;
		main_addr = '0;
		snd_addr  = '0;
		snd_vma   = 1'b0;
		audio     = '0;
		repeat (8) @(posedge clk_sys);
		#2;
		arst_n = 1'b1;

		start_test("reset_and_load");
		check("core_reset after reset", 32'd1, 32'(core_reset), 32'd0);
		check("rom_loaded after reset", 32'd0, 32'(rom_loaded), 32'd0);
		reset_held = 1'b1;
		start_download(ROM_INDEX);
		for (int a = 0; a < MAIN_SIZE + SND_SIZE; a++) begin
			r      = $random(seed);
			addr16 = 16'(a);
			if (addr16 < SND_BASE)
				main_model[addr16[14:0]] = r[7:0];
			else
				snd_model[11'(addr16 - SND_BASE)] = r[7:0];
			send_byte(addr16, r[7:0]);
			if (!core_reset)
				reset_held = 1'b0;
		end
		stop_download();
		check("core_reset during download", 32'd1, 32'(reset_held), 32'd0);
		step();
		check("rom_loaded after download", 32'd1, 32'(rom_loaded), 32'd0);
		check("core_reset while loading ends", 32'd1, 32'(core_reset), 32'd0);
		step();
		check("core_reset released", 32'd0, 32'(core_reset), 32'd0);
		end_test();

		start_test("main_readback");
		repeat (500) begin
			r = $random(seed);
			read_main(15'(r % MAIN_SIZE));
		end
		end_test();

		start_test("snd_readback");
		repeat (200) begin
			r = $random(seed);
			read_snd(r[10:0]);
		end
		// Download under a foreign index leaves both regions alone
		start_download(8'hff);
		check("core_reset during foreign download", 32'd1, 32'(core_reset), 32'd0);
		repeat (16) begin
			r = $random(seed);
			ff_main.push_back(15'(r % MAIN_SIZE));
			send_byte({1'b0, ff_main[$]}, r[31:24]);
			r = $random(seed);
			ff_snd.push_back(r[10:0]);
			send_byte(SND_BASE + {5'b00000, ff_snd[$]}, r[31:24]);
		end
		stop_download();
		foreach (ff_main[k])
			read_main(ff_main[k]);
		foreach (ff_snd[k])
			read_snd(ff_snd[k]);
		end_test();

		start_test("port_mapping");
		for (int v = 0; v < 4; v++) begin
			variant = game_e'(2'(v));
			repeat (300) begin
				r        = $random(seed);
				controls = r[11:0];
				status   = r[19:12];
				status.advance_btn  = 1'b0;
				status.hs_reset_btn = 1'b0;
				#1;
				check($sformatf("ports %s", variant.name()),
					32'(expected_ports(variant, controls, status, 1'b0, 1'b0)),
					32'(ports), 32'd0);
				step();
				// ROM is loaded, so only the host request holds the core
				check("core_reset from reset_req", 32'(status.reset_req),
					32'(core_reset), 32'd0);
			end
		end
		end_test();

		pulse_test("advance_pulse", 1'b0, 3'd1);
		pulse_test("hs_reset_pulse", 1'b1, 3'd3);

		start_test("audio_density");
		repeat (8) begin
			r     = $random(seed);
			value = r[7:0];
			audio = value;
			ones  = 0;
			repeat (2048) begin
				step();
				if (audio_out)
					ones++;
			end
			// Level is value * 32, so 2048 cycles give about value ones
			check($sformatf("ones for audio %02h", value), 32'(value), 32'(ones), 32'd1);
		end
		end_test();

		$display("Checks: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- arcade_shell.f
source/arcade_pkg.sv
source/loader_pkg.sv
source/button_stretch.sv
source/control_mapper.sv
source/rom_loader.sv
source/rom_store.sv
source/audio_dac.sv
source/arcade_shell.sv
test/tb_arcade_shell.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_arcade_shell
FILELIST  ?= arcade_shell.f

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := obj_dir/V$(TOP)
LOG     := sim.log

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
